//--- frv_pkg.sv
package frv_pkg;

    // ----------------------------------------------
    // Widths and sizes
    // ----------------------------------------------

    localparam int XLEN       = 32;                 // Data path width
    localparam int XL         = XLEN - 1;           // Top bit index
    localparam int REG_ADDR_W = 5;                  // GPR address width
    localparam int NUM_GPRS   = 1 << REG_ADDR_W;    // Register count
    localparam int DMEM_WORDS = 16;                 // Scratch memory depth
    localparam int DMEM_AW    = $clog2(DMEM_WORDS); // Word index width, byte addr bits 5:2
    localparam int OPR_SRC_W  = 5;                  // One bit per operand source

    // Micro-op codes
    typedef enum logic [2:0] {
        UOP_ADD   = 3'd0,
        UOP_SUB   = 3'd1,
        UOP_AND   = 3'd2,
        UOP_OR    = 3'd3,
        UOP_XOR   = 3'd4,
        UOP_SLT   = 3'd5,                           // Signed compare, result 1 or 0
        UOP_LOAD  = 3'd6,
        UOP_STORE = 3'd7
    } uop_t;

    // Bit positions inside opr_src
    typedef enum logic [2:0] {
        OPRA_RS1  = 3'd0,                           // A from rs1
        OPRA_PCIM = 3'd1,                           // A from pc + imm
        OPRB_RS2  = 3'd2,                           // B from rs2
        OPRB_IMM  = 3'd3,                           // B from immediate
        OPRC_RS2  = 3'd4                            // C from rs2, store data
    } opr_sel_t;

    // ----------------------------------------------
    // Stage payloads
    // ----------------------------------------------

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;                  // Destination register
        logic [REG_ADDR_W-1:0] rs1;                 // Source register 1
        logic [REG_ADDR_W-1:0] rs2;                 // Source register 2
        logic [XL:0]           imm;                 // Decoded immediate
        logic [XL:0]           pc;                  // Program counter
        uop_t                  uop;                 // Micro-op
        logic [OPR_SRC_W-1:0]  opr_src;             // Operand source selects
    } dispatch_in_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XL:0]           pc;
        uop_t                  uop;
        logic [XL:0]           opr_a;
        logic [XL:0]           opr_b;
        logic [XL:0]           opr_c;               // Store data
    } exec_op_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XL:0]           pc;
        uop_t                  uop;
        logic [XL:0]           result;              // ALU result or byte address
        logic [XL:0]           store_data;
    } wb_op_t;

    typedef struct packed {
        logic [XL:0]           pc;
        logic [REG_ADDR_W-1:0] rd;                  // Zero for stores
        logic [XL:0]           wdata;
    } retire_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;                  // Zero means nothing to forward
        logic [XL:0]           wdata;
        logic                  load;                // Data not ready yet
    } fwd_t;

    localparam int EXEC_OP_W = $bits(exec_op_t);    // Dispatch register width
    localparam int WB_OP_W   = $bits(wb_op_t);      // Execute register width

endpackage

//--- frv_gprs.sv
`timescale 1ns/1ps

module frv_gprs
    import frv_pkg::*;
(
    input  logic                  g_clk,            // Core clock
    input  logic                  reset,            // Sync reset, clears all registers
    input  logic [REG_ADDR_W-1:0] rs1_addr,         // Read port 1 address
    output logic [XL:0]           rs1_data,         // Read port 1 data
    input  logic [REG_ADDR_W-1:0] rs2_addr,         // Read port 2 address
    output logic [XL:0]           rs2_data,         // Read port 2 data
    input  logic                  rd_wen,           // Write enable
    input  logic [REG_ADDR_W-1:0] rd_addr,          // Write address
    input  logic [XL:0]           rd_data           // Write data
);

    logic [XL:0] regs [NUM_GPRS];                   // Register array

    // x0 always reads as zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge g_clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_GPRS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen && rd_addr != '0) begin // Writes to x0 dropped
            regs[rd_addr] <= rd_data;
        end
    end

endmodule

//--- frv_pipeline_register.sv
`timescale 1ns/1ps

module frv_pipeline_register #(
    parameter int RLEN = 32                         // Payload width
) (
    input  logic            g_clk,                  // Core clock
    input  logic            reset,                  // Sync reset
    input  logic [RLEN-1:0] i_data,                 // Payload from stage N
    input  logic            i_valid,                // Stage N has data
    output logic            o_busy,                 // Cannot take data this cycle
    input  logic            flush,                  // Drop the held entry
    output logic [RLEN-1:0] o_data,                 // Payload to stage N+1
    output logic            o_valid,                // Entry held
    input  logic            i_busy                  // Stage N+1 stalled
);

    logic accept;                                   // Slot free or draining

    // ----------------------------------------------
    // Handshake
    // ----------------------------------------------

    assign accept = !o_valid || !i_busy;
    assign o_busy = !accept;

    always_ff @(posedge g_clk) begin
        if (reset) begin
            o_valid <= 1'b0;
        end else if (flush) begin
            o_valid <= 1'b0;                        // Flush beats a new input
        end else if (accept) begin
            o_valid <= i_valid;
        end
    end

    // Payload only moves on a real transfer
    always_ff @(posedge g_clk) begin
        if (accept && i_valid) begin
            o_data <= i_data;
        end
    end

endmodule

//--- frv_pipeline_dispatch.sv
`timescale 1ns/1ps

module frv_pipeline_dispatch
    import frv_pkg::*;
(
    input  logic                  g_clk,            // Core clock
    input  logic                  reset,            // Sync reset

    output logic                  s2_p_busy,        // Cannot accept this cycle
    input  logic                  s2_p_valid,       // Incoming micro-op valid
    input  dispatch_in_t          s2_op,            // Incoming micro-op

    input  logic                  flush,            // Drop dispatch register

    input  fwd_t                  fwd_s3,           // Execute stage result
    input  fwd_t                  fwd_s4,           // Writeback stage result

    input  logic                  gpr_wen,          // GPR write from writeback
    input  logic [REG_ADDR_W-1:0] gpr_rd,
    input  logic [XL:0]           gpr_wdata,

    output exec_op_t              s3_op,            // Operands for execute
    output logic                  s3_p_valid,
    input  logic                  s3_p_busy
);

    logic [XL:0] s2_rs1_data;                       // Raw register file reads
    logic [XL:0] s2_rs2_data;
    logic [XL:0] dis_rs1;                           // Reads after forwarding
    logic [XL:0] dis_rs2;
    logic [XL:0] pc_plus_imm;
    logic        fwd_s3_rs1;
    logic        fwd_s4_rs1;
    logic        fwd_s3_rs2;
    logic        fwd_s4_rs2;
    logic        dis_bubble;                        // Load-use stall
    logic        p_busy;                            // Dispatch register full
    exec_op_t    n_s3_op;

    // ----------------------------------------------
    // Load-use bubble
    // ----------------------------------------------

    // Load data not known until writeback, so hold the consumer one cycle
    assign dis_bubble = s2_p_valid && fwd_s3.load && fwd_s3.rd != '0 &&
                        (s2_op.rs1 == fwd_s3.rd || s2_op.rs2 == fwd_s3.rd);

    assign s2_p_busy = dis_bubble || p_busy;

    // ----------------------------------------------
    // Forwarding
    // ----------------------------------------------

    assign fwd_s3_rs1 = s2_op.rs1 == fwd_s3.rd && s2_op.rs1 != '0;
    assign fwd_s4_rs1 = s2_op.rs1 == fwd_s4.rd && s2_op.rs1 != '0;
    assign fwd_s3_rs2 = s2_op.rs2 == fwd_s3.rd && s2_op.rs2 != '0;
    assign fwd_s4_rs2 = s2_op.rs2 == fwd_s4.rd && s2_op.rs2 != '0;

    // Youngest producer wins
    assign dis_rs1 = fwd_s3_rs1 ? fwd_s3.wdata :
                     fwd_s4_rs1 ? fwd_s4.wdata :
                                  s2_rs1_data;

    assign dis_rs2 = fwd_s3_rs2 ? fwd_s3.wdata :
                     fwd_s4_rs2 ? fwd_s4.wdata :
                                  s2_rs2_data;

    assign pc_plus_imm = s2_op.pc + s2_op.imm;

    // ----------------------------------------------
    // Operand sourcing
    // ----------------------------------------------

    always_comb begin
        n_s3_op.rd    = s2_op.rd;
        n_s3_op.pc    = s2_op.pc;
        n_s3_op.uop   = s2_op.uop;
        n_s3_op.opr_a = ({XLEN{s2_op.opr_src[OPRA_RS1]}}  & dis_rs1) |
                        ({XLEN{s2_op.opr_src[OPRA_PCIM]}} & pc_plus_imm);
        n_s3_op.opr_b = ({XLEN{s2_op.opr_src[OPRB_RS2]}}  & dis_rs2) |
                        ({XLEN{s2_op.opr_src[OPRB_IMM]}}  & s2_op.imm);
        n_s3_op.opr_c =  {XLEN{s2_op.opr_src[OPRC_RS2]}}  & dis_rs2;
    end

    frv_gprs i_gprs (
        .g_clk    (g_clk),
        .reset    (reset),
        .rs1_addr (s2_op.rs1),
        .rs1_data (s2_rs1_data),
        .rs2_addr (s2_op.rs2),
        .rs2_data (s2_rs2_data),
        .rd_wen   (gpr_wen),
        .rd_addr  (gpr_rd),
        .rd_data  (gpr_wdata)
    );

    // Bubble cycle loads an empty entry
    frv_pipeline_register #(
        .RLEN (EXEC_OP_W)
    ) i_dispatch_pipe_reg (
        .g_clk   (g_clk),
        .reset   (reset),
        .i_data  (n_s3_op),
        .i_valid (s2_p_valid && !dis_bubble),
        .o_busy  (p_busy),
        .flush   (flush),
        .o_data  (s3_op),
        .o_valid (s3_p_valid),
        .i_busy  (s3_p_busy)
    );

endmodule

//--- frv_pipeline_execute.sv
`timescale 1ns/1ps

module frv_pipeline_execute
    import frv_pkg::*;
(
    input  logic     g_clk,                         // Core clock
    input  logic     reset,                         // Sync reset
    input  logic     flush,                         // Kill the s3 entry

    input  exec_op_t s3_op,                         // Operands from dispatch
    input  logic     s3_p_valid,
    output logic     s3_p_busy,

    output fwd_t     fwd_s3,                        // Result back to dispatch

    output wb_op_t   s4_op,                         // To writeback
    output logic     s4_p_valid,
    input  logic     s4_p_busy
);

    logic [XL:0] alu_result;
    logic        is_store;
    wb_op_t      n_s4_op;

    // ----------------------------------------------
    // ALU and address generation
    // ----------------------------------------------

    always_comb begin
        unique case (s3_op.uop)
            UOP_SUB: alu_result = s3_op.opr_a - s3_op.opr_b;
            UOP_AND: alu_result = s3_op.opr_a & s3_op.opr_b;
            UOP_OR:  alu_result = s3_op.opr_a | s3_op.opr_b;
            UOP_XOR: alu_result = s3_op.opr_a ^ s3_op.opr_b;
            UOP_SLT: alu_result = {{XL{1'b0}},
                                   $signed(s3_op.opr_a) < $signed(s3_op.opr_b)};
            default: alu_result = s3_op.opr_a + s3_op.opr_b; // Add, load, store addr
        endcase
    end

    assign is_store = s3_op.uop == UOP_STORE;

    // Stores never write a register
    always_comb begin
        n_s4_op.rd         = is_store ? '0 : s3_op.rd;
        n_s4_op.pc         = s3_op.pc;
        n_s4_op.uop        = s3_op.uop;
        n_s4_op.result     = alu_result;
        n_s4_op.store_data = s3_op.opr_c;
    end

    // For a load this is the address, dispatch bubbles on it
    assign fwd_s3.rd    = s3_p_valid ? n_s4_op.rd : '0;
    assign fwd_s3.wdata = alu_result;
    assign fwd_s3.load  = s3_op.uop == UOP_LOAD;

    // s4 is never flushed, so the s3 entry must not slip past a flush
    frv_pipeline_register #(
        .RLEN (WB_OP_W)
    ) i_execute_pipe_reg (
        .g_clk   (g_clk),
        .reset   (reset),
        .i_data  (n_s4_op),
        .i_valid (s3_p_valid && !flush),
        .o_busy  (s3_p_busy),
        .flush   (1'b0),
        .o_data  (s4_op),
        .o_valid (s4_p_valid),
        .i_busy  (s4_p_busy)
    );

endmodule

//--- frv_pipeline_writeback.sv
`timescale 1ns/1ps

module frv_pipeline_writeback
    import frv_pkg::*;
(
    input  logic                  g_clk,            // Core clock
    input  logic                  reset,            // Sync reset, clears memory

    input  wb_op_t                s4_op,            // Result from execute
    input  logic                  s4_p_valid,
    output logic                  s4_p_busy,

    output logic                  gpr_wen,          // Register file write
    output logic [REG_ADDR_W-1:0] gpr_rd,
    output logic [XL:0]           gpr_wdata,

    output fwd_t                  fwd_s4,           // Final value back to dispatch

    output retire_t               retire,           // Retire record
    output logic                  retire_valid,
    input  logic                  retire_busy
);

    logic [XL:0]        dmem [DMEM_WORDS];          // Scratch data memory
    logic [DMEM_AW-1:0] dmem_idx;                   // Word index
    logic [XL:0]        wdata;
    logic               is_load;
    logic               is_store;
    logic               xfer;                       // Retiring this cycle

    // ----------------------------------------------
    // Memory access
    // ----------------------------------------------

    assign dmem_idx = s4_op.result[DMEM_AW+1:2];
    assign is_load  = s4_op.uop == UOP_LOAD;
    assign is_store = s4_op.uop == UOP_STORE;
    assign xfer     = s4_p_valid && !retire_busy;

    always_ff @(posedge g_clk) begin
        if (reset) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (xfer && is_store) begin
            dmem[dmem_idx] <= s4_op.store_data;
        end
    end

    // Load returns the word, store reports its data
    assign wdata = is_load  ? dmem[dmem_idx]   :
                   is_store ? s4_op.store_data :
                              s4_op.result;

    // ----------------------------------------------
    // Register write, forwarding, retire
    // ----------------------------------------------

    assign gpr_wen   = xfer && !is_store && s4_op.rd != '0;
    assign gpr_rd    = s4_op.rd;
    assign gpr_wdata = wdata;

    assign fwd_s4.rd    = (s4_p_valid && !is_store) ? s4_op.rd : '0;
    assign fwd_s4.wdata = wdata;
    assign fwd_s4.load  = is_load;

    assign retire.pc    = s4_op.pc;
    assign retire.rd    = is_store ? '0 : s4_op.rd;
    assign retire.wdata = wdata;
    assign retire_valid = s4_p_valid;
    assign s4_p_busy    = retire_busy;              // Retire port stalls s4

endmodule

//--- frv_backend.sv
`timescale 1ns/1ps

module frv_backend
    import frv_pkg::*;
(
    input  logic         g_clk,                     // Core clock
    input  logic         reset,                     // Sync reset

    input  logic         s2_p_valid,                // Dispatch port
    output logic         s2_p_busy,
    input  dispatch_in_t s2_op,

    input  logic         flush,                     // Kill dispatch and execute entries

    output logic         retire_valid,              // Retire port
    input  logic         retire_busy,
    output retire_t      retire
);

    // ----------------------------------------------
    // Stage wiring
    // ----------------------------------------------

    exec_op_t              s3_op;
    logic                  s3_p_valid;
    logic                  s3_p_busy;
    wb_op_t                s4_op;
    logic                  s4_p_valid;
    logic                  s4_p_busy;
    fwd_t                  fwd_s3;
    fwd_t                  fwd_s4;
    logic                  gpr_wen;
    logic [REG_ADDR_W-1:0] gpr_rd;
    logic [XL:0]           gpr_wdata;

    frv_pipeline_dispatch i_dispatch (
        .g_clk      (g_clk),
        .reset      (reset),
        .s2_p_busy  (s2_p_busy),
        .s2_p_valid (s2_p_valid),
        .s2_op      (s2_op),
        .flush      (flush),
        .fwd_s3     (fwd_s3),
        .fwd_s4     (fwd_s4),
        .gpr_wen    (gpr_wen),
        .gpr_rd     (gpr_rd),
        .gpr_wdata  (gpr_wdata),
        .s3_op      (s3_op),
        .s3_p_valid (s3_p_valid),
        .s3_p_busy  (s3_p_busy)
    );

    frv_pipeline_execute i_execute (
        .g_clk      (g_clk),
        .reset      (reset),
        .flush      (flush),
        .s3_op      (s3_op),
        .s3_p_valid (s3_p_valid),
        .s3_p_busy  (s3_p_busy),
        .fwd_s3     (fwd_s3),
        .s4_op      (s4_op),
        .s4_p_valid (s4_p_valid),
        .s4_p_busy  (s4_p_busy)
    );

    frv_pipeline_writeback i_writeback (
        .g_clk        (g_clk),
        .reset        (reset),
        .s4_op        (s4_op),
        .s4_p_valid   (s4_p_valid),
        .s4_p_busy    (s4_p_busy),
        .gpr_wen      (gpr_wen),
        .gpr_rd       (gpr_rd),
        .gpr_wdata    (gpr_wdata),
        .fwd_s4       (fwd_s4),
        .retire       (retire),
        .retire_valid (retire_valid),
        .retire_busy  (retire_busy)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic g_clk,                             // 8 ns core clock
    output logic reset                              // Sync reset, high for 8 cycles
);

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;                  // Half period
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge g_clk);
        #1 reset = 1'b0;                            // Released just after the edge
    end

endmodule

//--- frv_backend_properties.sv
`timescale 1ns/1ps

module frv_backend_properties
    import frv_pkg::*;
(
    input logic                  g_clk,
    input logic                  reset,
    input logic                  flush,
    input logic                  s3_p_valid,        // Dispatch register output
    input logic                  s3_p_busy,
    input exec_op_t              s3_op,
    input logic                  gpr_wen,           // Register file write port
    input logic [REG_ADDR_W-1:0] gpr_rd,
    input logic                  retire_valid,      // Retire port
    input logic                  retire_busy,
    input retire_t               retire
);

    logic in_reset;                                 // Reset seen at the last edge

    always_ff @(posedge g_clk) begin
        in_reset <= reset;
    end

    // ----------------------------------------------
    // Handshake rules
    // ----------------------------------------------

    // Valids are cleared one edge after reset is first seen
    reset_clears_valid: assert property (@(posedge g_clk)
        in_reset |-> !retire_valid && !s3_p_valid)
        else $error("valid output high during reset");

    retire_held_stable: assert property (@(posedge g_clk) disable iff (reset)
        retire_valid && retire_busy |=> retire_valid && $stable(retire))
        else $error("retire record changed while stalled");

    // A flush may legally drop the stalled s3 entry
    s3_held_stable: assert property (@(posedge g_clk) disable iff (reset)
        s3_p_valid && s3_p_busy && !flush |=> s3_p_valid && $stable(s3_op))
        else $error("s3 entry changed while stalled");

    no_x0_write: assert property (@(posedge g_clk) disable iff (reset)
        gpr_wen |-> gpr_rd != '0)
        else $error("register write to x0");

endmodule

bind frv_backend frv_backend_properties props_inst (
    .g_clk        (g_clk),
    .reset        (reset),
    .flush        (flush),
    .s3_p_valid   (s3_p_valid),
    .s3_p_busy    (s3_p_busy),
    .s3_op        (s3_op),
    .gpr_wen      (gpr_wen),
    .gpr_rd       (gpr_rd),
    .retire_valid (retire_valid),
    .retire_busy  (retire_busy),
    .retire       (retire)
);

//--- tb_frv_backend.sv
`timescale 1ns/1ps

module tb_frv_backend
    import frv_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000;           // Sum of test lengths with margin

    logic         g_clk;
    logic         reset;
    logic         s2_p_valid;
    logic         s2_p_busy;
    dispatch_in_t s2_op;
    logic         flush;
    logic         retire_valid;
    logic         retire_busy;
    retire_t      retire;

    logic [XL:0]  model_regs [NUM_GPRS];            // Reference register file
    logic [XL:0]  model_mem [DMEM_WORDS];           // Reference scratch memory
    retire_t      exp_q [$];                        // Predicted retire records, in order
    logic         busy_log [$];                     // s2_p_busy per cycle of the last send
    logic [XL:0]  next_pc = 32'h0000_1000;
    logic         saw_busy = 1'b0;
    logic         bp_en = 1'b0;                     // Random retire stalls on
    logic [XL:0]  bp_rnd;
    integer       seed = 25421;
    int           cycle_count = 0;
    int           mismatch_count = 0;
    int           other_errors = 0;

    tb_clock_gen clock_gen_inst (
        .g_clk (g_clk),
        .reset (reset)
    );

    frv_backend frv_backend_inst (
        .g_clk        (g_clk),
        .reset        (reset),
        .s2_p_valid   (s2_p_valid),
        .s2_p_busy    (s2_p_busy),
        .s2_op        (s2_op),
        .flush        (flush),
        .retire_valid (retire_valid),
        .retire_busy  (retire_busy),
        .retire       (retire)
    );

    // ----------------------------------------------
    // Stimulus helpers and reference model
    // ----------------------------------------------

    function automatic logic [XL:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [OPR_SRC_W-1:0] srcs(input opr_sel_t a_sel, input opr_sel_t b_sel,
                                                  input logic with_c);
        logic [OPR_SRC_W-1:0] s;
        s = '0;
        s[a_sel] = 1'b1;
        s[b_sel] = 1'b1;
        s[OPRC_RS2] = with_c;                       // Store data
        return s;
    endfunction

    function automatic dispatch_in_t make_op(input uop_t uop, input int rd, input int rs1,
                                             input int rs2, input logic [XL:0] imm,
                                             input logic [OPR_SRC_W-1:0] src);
        dispatch_in_t op;
        op.rd = REG_ADDR_W'(rd);
        op.rs1 = REG_ADDR_W'(rs1);
        op.rs2 = REG_ADDR_W'(rs2);
        op.imm = imm;
        op.pc = '0;                                 // Filled in by send
        op.uop = uop;
        op.opr_src = src;
        return op;
    endfunction

    // Program order model, updates state and gives the retire record
    task automatic predict(input dispatch_in_t op, output retire_t rec);
        logic [XL:0] rs1_v;
        logic [XL:0] rs2_v;
        logic [XL:0] a;
        logic [XL:0] b;
        logic [XL:0] addr;
        logic [XL:0] res;
        rs1_v = (op.rs1 == '0) ? '0 : model_regs[op.rs1];
        rs2_v = (op.rs2 == '0) ? '0 : model_regs[op.rs2];
        a = op.opr_src[OPRA_PCIM] ? op.pc + op.imm : rs1_v;
        b = op.opr_src[OPRB_IMM] ? op.imm : rs2_v;
        addr = a + b;
        rec.pc = op.pc;
        rec.rd = op.rd;
        case (op.uop)
            UOP_ADD:   res = a + b;
            UOP_SUB:   res = a - b;
            UOP_AND:   res = a & b;
            UOP_OR:    res = a | b;
            UOP_XOR:   res = a ^ b;
            UOP_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            UOP_LOAD:  res = model_mem[addr[5:2]];  // Word index
            UOP_STORE: begin
                res = rs2_v;                        // Retires its data, no rd
                model_mem[addr[5:2]] = rs2_v;
                rec.rd = '0;
            end
        endcase
        rec.wdata = res;
        if (rec.rd != '0) begin
            model_regs[rec.rd] = res;
        end
    endtask

    // Presents one op and returns once it is taken, at posedge + 1
    task automatic send(input dispatch_in_t op, input logic keep);
        retire_t rec;
        logic    accepted;
        op.pc = next_pc;
        next_pc = next_pc + 4;
        if (keep) begin
            predict(op, rec);
            exp_q.push_back(rec);
        end
        s2_op = op;
        s2_p_valid = 1'b1;
        busy_log.delete();
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge g_clk);                       // Inputs settled mid cycle
            busy_log.push_back(s2_p_busy);
            saw_busy = saw_busy | s2_p_busy;
            accepted = !s2_p_busy;
            @(posedge g_clk);
            #1;
        end
    endtask

    task automatic drain();
        s2_p_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge g_clk);
        end
        repeat (2) @(posedge g_clk);                // Last register write lands
        #1;
    endtask

    // ----------------------------------------------
    // Checks
    // ----------------------------------------------

    task automatic check_retire(input retire_t got, input retire_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: retire pc %h rd %0d wdata %h, exp pc %h rd %0d wdata %h",
                     $time, got.pc, got.rd, got.wdata, exp.pc, exp.rd, exp.wdata);
        end
    endtask

    task automatic check_busy(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: %s, s2_p_busy %b expected %b", $time, what, got, exp);
        end
    endtask

    // Retire transfers are decided at the next edge
    always @(negedge g_clk) begin
        if (!reset && retire_valid && !retire_busy) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("error at %0t: unexpected retire of pc %h", $time, retire.pc);
            end else begin
                check_retire(retire, exp_q.pop_front());
            end
        end
    end

    initial begin
        logic stall;
        retire_busy = 1'b0;
        forever begin
            @(negedge g_clk);
            bp_rnd = rand_word();                   // Stall pattern for the next cycle
            stall = bp_en && bp_rnd[0];             // About half the cycles stalled
            @(posedge g_clk);
            #1;
            retire_busy = stall;
        end
    end

    always @(posedge g_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, pipeline stopped retiring", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ----------------------------------------------
    // Directed tests
    // ----------------------------------------------

    task automatic test_alu_ops();
        for (int r = 1; r <= 4; r++) begin
            send(make_op(UOP_ADD, r, 0, 0, rand_word(), srcs(OPRA_RS1, OPRB_IMM, 1'b0)), 1'b1);
        end
        send(make_op(UOP_ADD, 5, 0, 0, 32'h8000_0010, srcs(OPRA_RS1, OPRB_IMM, 1'b0)), 1'b1);
        for (int u = 0; u < 6; u++) begin
            send(make_op(uop_t'(3'(u)), 10 + u, 1 + u % 4, 5, 0,
                         srcs(OPRA_RS1, OPRB_RS2, 1'b0)), 1'b1);
            send(make_op(uop_t'(3'(u)), 16 + u, 5, 0, rand_word(),
                         srcs(OPRA_RS1, OPRB_IMM, 1'b0)), 1'b1);
        end
        send(make_op(UOP_SLT, 22, 5, 0, 32'd5, srcs(OPRA_RS1, OPRB_IMM, 1'b0)), 1'b1);
        send(make_op(UOP_SLT, 23, 0, 5, 0, srcs(OPRA_RS1, OPRB_RS2, 1'b0)), 1'b1);
        send(make_op(UOP_ADD, 24, 0, 2, 32'h40, srcs(OPRA_PCIM, OPRB_RS2, 1'b0)), 1'b1);
        drain();
    endtask

    task automatic test_forwarding();
        saw_busy = 1'b0;
        send(make_op(UOP_ADD, 7, 0, 0, 32'd100, srcs(OPRA_RS1, OPRB_IMM, 1'b0)), 1'b1);
        send(make_op(UOP_ADD, 8, 7, 0, 32'd1, srcs(OPRA_RS1, OPRB_IMM, 1'b0)), 1'b1);
        send(make_op(UOP_ADD, 9, 7, 8, 0, srcs(OPRA_RS1, OPRB_RS2, 1'b0)), 1'b1);
        send(make_op(UOP_ADD, 10, 0, 0, 32'd3, srcs(OPRA_RS1, OPRB_IMM, 1'b0)), 1'b1);
        send(make_op(UOP_SUB, 11, 9, 8, 0, srcs(OPRA_RS1, OPRB_RS2, 1'b0)), 1'b1);
        send(make_op(UOP_ADD, 0, 0, 0, 32'd77, srcs(OPRA_RS1, OPRB_IMM, 1'b0)), 1'b1);
        send(make_op(UOP_OR, 12, 0, 7, 0, srcs(OPRA_RS1, OPRB_RS2, 1'b0)), 1'b1);
        drain();
        check_busy(saw_busy, 1'b0, "dependent chain stalled");
    endtask

    task automatic test_load_use();
        send(make_op(UOP_ADD, 13, 0, 0, rand_word(), srcs(OPRA_RS1, OPRB_IMM, 1'b0)), 1'b1);
        send(make_op(UOP_ADD, 14, 0, 0, 32'd8, srcs(OPRA_RS1, OPRB_IMM, 1'b0)), 1'b1);
        send(make_op(UOP_STORE, 0, 14, 13, 32'd4, srcs(OPRA_RS1, OPRB_IMM, 1'b1)), 1'b1);
        send(make_op(UOP_LOAD, 15, 14, 0, 32'd4, srcs(OPRA_RS1, OPRB_IMM, 1'b0)), 1'b1);
        send(make_op(UOP_ADD, 16, 15, 13, 0, srcs(OPRA_RS1, OPRB_RS2, 1'b0)), 1'b1);
        // Busy in the first cycle only, then taken
        foreach (busy_log[i]) begin
            check_busy(busy_log[i], i == 0, "load consumer stall not exactly one cycle");
        end
        drain();
    endtask

    task automatic test_back_pressure();
        logic [XL:0] rnd;
        logic [XL:0] addr;
        bp_en = 1'b1;
        saw_busy = 1'b0;
        for (int i = 0; i < 24; i++) begin
            rnd = rand_word();
            addr = {26'd0, rnd[17:14], 2'b00};      // Any of the 16 words
            case (uop_t'(rnd[2:0]))
                UOP_STORE: send(make_op(UOP_STORE, 0, 0, 1 + int'(rnd[5:3]), addr,
                                        srcs(OPRA_RS1, OPRB_IMM, 1'b1)), 1'b1);
                UOP_LOAD:  send(make_op(UOP_LOAD, 1 + int'(rnd[5:3]), 0, 0, addr,
                                        srcs(OPRA_RS1, OPRB_IMM, 1'b0)), 1'b1);
                default:   send(make_op(uop_t'(rnd[2:0]), 1 + int'(rnd[5:3]),
                                        1 + int'(rnd[8:6]), 1 + int'(rnd[11:9]),
                                        {24'd0, rnd[31:24]},
                                        rnd[12] ? srcs(OPRA_RS1, OPRB_RS2, 1'b0) :
                                                  srcs(OPRA_RS1, OPRB_IMM, 1'b0)), 1'b1);
            endcase
        end
        drain();
        bp_en = 1'b0;
        check_busy(saw_busy, 1'b1, "dispatch never stalled under back-pressure");
    endtask

    // Older op sits in s4 and survives, younger one in s3 is dropped
    task automatic test_flush();
        send(make_op(UOP_ADD, 20, 0, 0, 32'd11, srcs(OPRA_RS1, OPRB_IMM, 1'b0)), 1'b1);
        send(make_op(UOP_ADD, 21, 0, 0, 32'd500, srcs(OPRA_RS1, OPRB_IMM, 1'b0)), 1'b1);
        send(make_op(UOP_ADD, 20, 0, 0, 32'd999, srcs(OPRA_RS1, OPRB_IMM, 1'b0)), 1'b0);
        s2_p_valid = 1'b0;
        flush = 1'b1;
        @(posedge g_clk);
        #1;
        flush = 1'b0;
        send(make_op(UOP_ADD, 25, 20, 21, 0, srcs(OPRA_RS1, OPRB_RS2, 1'b0)), 1'b1);
        drain();
    endtask

    initial begin
        s2_p_valid = 1'b0;
        s2_op = '0;
        flush = 1'b0;
        for (int i = 0; i < NUM_GPRS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        @(negedge reset);
        @(posedge g_clk);
        #1;
        test_alu_ops();
        test_forwarding();
        test_load_use();
        test_back_pressure();
        test_flush();
        $display("checks done: %0d mismatches, %0d other errors", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
frv_pkg.sv
frv_gprs.sv
frv_pipeline_register.sv
frv_pipeline_dispatch.sv
frv_pipeline_execute.sv
frv_pipeline_writeback.sv
frv_backend.sv
tb_clock_gen.sv
frv_backend_properties.sv
tb_frv_backend.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the frv_backend testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_frv_backend \
    -f tb.f \
    -o sim_frv_backend

./obj_dir/sim_frv_backend | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
